/* verilog/matrix_game_defines.svh */
// Build-time constants for the falling-dot game on the MAX7219 matrix
// Include in any RTL or testbench file that needs timing, background or spawn values
`ifndef MATRIX_GAME_DEFINES_SVH
`define MATRIX_GAME_DEFINES_SVH

// Timing in clock_50 cycles
`define MG_DEBOUNCE_CYCLES 4
`define MG_FALL_TICKS      2000
`define MG_SCLK_HALF       2
`define MG_QUEUE_DEPTH     2
`define MG_INTENSITY       4'hA

// Fixed background, bit j is column j
`define MG_BG_ROW0 8'b00000000
`define MG_BG_ROW1 8'b00000000
`define MG_BG_ROW2 8'b11100000
`define MG_BG_ROW3 8'b00000000
`define MG_BG_ROW4 8'b11100000
`define MG_BG_ROW5 8'b00000000
`define MG_BG_ROW6 8'b00000000
`define MG_BG_ROW7 8'b00000000

`define MG_SPAWN_ROW 3'd7
`define MG_SPAWN_COL 3'd4

`endif

/* verilog/matrix_game_pkg.sv */
// Shared types for the falling-dot game
// RTL and testbench reach these by scoped name
package matrix_game_pkg;

	typedef enum logic [1:0] {
		GS_IDLE,
		GS_FALL,
		GS_LANDED
	} game_state_t;

	// MAX7219 register addresses
	typedef enum logic [3:0] {
		REG_DIGIT0     = 4'd1,
		REG_DIGIT1     = 4'd2,
		REG_DIGIT2     = 4'd3,
		REG_DIGIT3     = 4'd4,
		REG_DIGIT4     = 4'd5,
		REG_DIGIT5     = 4'd6,
		REG_DIGIT6     = 4'd7,
		REG_DIGIT7     = 4'd8,
		REG_DECODE     = 4'd9,
		REG_INTENSITY  = 4'd10,
		REG_SCAN_LIMIT = 4'd11,
		REG_SHUTDOWN   = 4'd12
	} max_reg_t;

	typedef logic [7:0] frame_row_t;
	typedef logic [2:0] row_idx_t;
	typedef logic [2:0] col_idx_t;

	// Upper nibble zero, then address, then data
	typedef logic [15:0] max_word_t;

endpackage

/* verilog/button_debounce.sv */
// Conditions one active-low push button
// Synchronises the pin, waits for a stable level and emits a one-cycle press pulse
`timescale 1ns/100ps
`include "matrix_game_defines.svh"

module button_debounce (
	input  logic clock_50,
	input  logic rst_n,
	input  logic btn_n,
	output logic press
);
	localparam int CNT_W = $clog2(`MG_DEBOUNCE_CYCLES + 1);

	logic [1:0]       sync;
	logic             level;
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync       <= 2'b00;
			level      <= 1'b0;
			stable_cnt <= '0;
			press      <= 1'b0;
		end else begin
			// Inverted so that a pressed button reads high
			sync  <= {sync[0], ~btn_n};
			press <= 1'b0;
			if (sync[1] == level) begin
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(`MG_DEBOUNCE_CYCLES - 1)) begin
				// Accept the new level and pulse only when it is a press
				level      <= sync[1];
				stable_cnt <= '0;
				press      <= sync[1];
			end else begin
				stable_cnt <= stable_cnt + CNT_W'(1);
			end
		end
	end

endmodule

/* verilog/dot_controller.sv */
// Game logic for the falling dot
// Steps the dot down on each fall tick and shifts it sideways on left or right presses
// The dot lands on the bottom row or on top of a lit background cell
`timescale 1ns/100ps
`include "matrix_game_defines.svh"

module dot_controller (
	input  logic                      clock_50,
	input  logic                      rst_n,
	input  logic                      start_press,
	input  logic                      left_press,
	input  logic                      right_press,
	output matrix_game_pkg::row_idx_t dot_row,
	output matrix_game_pkg::col_idx_t dot_col
);
	localparam int TICK_W = $clog2(`MG_FALL_TICKS);

	// Background map, cell (row, col) sits at bit 8*row+col
	localparam logic [63:0] BG_MAP = {
		`MG_BG_ROW7, `MG_BG_ROW6, `MG_BG_ROW5, `MG_BG_ROW4,
		`MG_BG_ROW3, `MG_BG_ROW2, `MG_BG_ROW1, `MG_BG_ROW0
	};

	matrix_game_pkg::game_state_t state;
	logic [TICK_W-1:0]            tick_cnt;
	logic                         fall_tick;
	matrix_game_pkg::row_idx_t    row_below;
	matrix_game_pkg::col_idx_t    col_left;
	matrix_game_pkg::col_idx_t    col_right;
	logic                         blocked_below;
	logic                         blocked_left;
	logic                         blocked_right;

	assign fall_tick     = (tick_cnt == TICK_W'(`MG_FALL_TICKS - 1));
	assign row_below     = dot_row - 3'd1;
	// Left rotates the column index up, right rotates it down
	assign col_left      = dot_col + 3'd1;
	assign col_right     = dot_col - 3'd1;
	assign blocked_below = (dot_row == 3'd0) || BG_MAP[{row_below, dot_col}];
	assign blocked_left  = BG_MAP[{dot_row, col_left}];
	assign blocked_right = BG_MAP[{dot_row, col_right}];

	// Fall tick counter, held at zero outside the falling state
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (state != matrix_game_pkg::GS_FALL || fall_tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + TICK_W'(1);
		end
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state   <= matrix_game_pkg::GS_IDLE;
			dot_row <= `MG_SPAWN_ROW;
			dot_col <= `MG_SPAWN_COL;
		end else begin
			case (state)
				matrix_game_pkg::GS_IDLE: begin
					dot_row <= `MG_SPAWN_ROW;
					dot_col <= `MG_SPAWN_COL;
					if (start_press) begin
						state <= matrix_game_pkg::GS_FALL;
					end
				end
				matrix_game_pkg::GS_FALL: begin
					// The tick wins over a sideways press in the same cycle
					if (fall_tick) begin
						if (blocked_below) begin
							state <= matrix_game_pkg::GS_LANDED;
						end else begin
							dot_row <= row_below;
						end
					end else if (left_press && !blocked_left) begin
						dot_col <= col_left;
					end else if (right_press && !blocked_right) begin
						dot_col <= col_right;
					end
				end
				matrix_game_pkg::GS_LANDED: begin
					if (start_press) begin
						state   <= matrix_game_pkg::GS_IDLE;
						dot_row <= `MG_SPAWN_ROW;
						dot_col <= `MG_SPAWN_COL;
					end
				end
				default: state <= matrix_game_pkg::GS_IDLE;
			endcase
		end
	end

endmodule

/* verilog/frame_composer.sv */
// Builds the MAX7219 word stream
// Sends the start-up commands once, then refreshes digit rows 0 to 7 forever
// A word is issued only while a serializer credit is held
`timescale 1ns/100ps
`include "matrix_game_defines.svh"

module frame_composer (
	input  logic                       clock_50,
	input  logic                       rst_n,
	input  matrix_game_pkg::row_idx_t  dot_row,
	input  matrix_game_pkg::col_idx_t  dot_col,
	input  logic                       credit_return,
	output logic                       word_valid,
	output matrix_game_pkg::max_word_t word
);
	localparam int         CREDIT_W   = $clog2(`MG_QUEUE_DEPTH + 1);
	localparam logic [3:0] POS_DIGIT0 = 4'd4;
	localparam logic [3:0] POS_DIGIT7 = 4'd11;
	localparam logic [3:0] DIGIT_BASE = matrix_game_pkg::REG_DIGIT0;
	localparam logic [63:0] BG_MAP = {
		`MG_BG_ROW7, `MG_BG_ROW6, `MG_BG_ROW5, `MG_BG_ROW4,
		`MG_BG_ROW3, `MG_BG_ROW2, `MG_BG_ROW1, `MG_BG_ROW0
	};

	logic [3:0]                  seq_pos;
	logic [CREDIT_W-1:0]         credit_cnt;
	logic                        issue;
	matrix_game_pkg::row_idx_t   digit_idx;
	matrix_game_pkg::frame_row_t frame_row;
	matrix_game_pkg::max_word_t  next_word;

	assign issue     = (credit_cnt != '0);
	assign digit_idx = 3'(seq_pos - POS_DIGIT0);

	// Background row with the dot laid over it
	always_comb begin
		frame_row = BG_MAP[{digit_idx, 3'd0} +: 8];
		if (dot_row == digit_idx) begin
			frame_row[dot_col] = 1'b1;
		end
	end

	always_comb begin
		case (seq_pos)
			4'd0:    next_word = {4'h0, matrix_game_pkg::REG_DECODE, 8'h00};
			4'd1:    next_word = {4'h0, matrix_game_pkg::REG_INTENSITY, 4'h0, `MG_INTENSITY};
			4'd2:    next_word = {4'h0, matrix_game_pkg::REG_SCAN_LIMIT, 8'h07};
			4'd3:    next_word = {4'h0, matrix_game_pkg::REG_SHUTDOWN, 8'h01};
			default: next_word = {4'h0, DIGIT_BASE + {1'b0, digit_idx}, frame_row};
		endcase
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			seq_pos    <= '0;
			credit_cnt <= CREDIT_W'(`MG_QUEUE_DEPTH);
			word_valid <= 1'b0;
		end else begin
			word_valid <= issue;
			credit_cnt <= credit_cnt - CREDIT_W'(issue) + CREDIT_W'(credit_return);
			// No credit means hold the current position
			if (issue) begin
				seq_pos <= (seq_pos == POS_DIGIT7) ? POS_DIGIT0 : seq_pos + 4'd1;
			end
		end
	end

	always_ff @(posedge clock_50) begin
		if (issue) begin
			word <= next_word;
		end
	end

endmodule

/* verilog/max7219_serializer.sv */
// Serial link to the MAX7219
// Queues incoming words and shifts each one out MSB first on din, framed by ncs
// One credit goes back to the composer per finished word
`timescale 1ns/100ps
`include "matrix_game_defines.svh"

module max7219_serializer (
	input  logic                       clock_50,
	input  logic                       rst_n,
	input  logic                       word_valid,
	input  matrix_game_pkg::max_word_t word,
	output logic                       max7219_din,
	output logic                       max7219_ncs,
	output logic                       max7219_clk,
	output logic                       credit_return
);
	localparam int PTR_W = $clog2(`MG_QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`MG_QUEUE_DEPTH + 1);
	localparam int DIV_W = $clog2(`MG_SCLK_HALF + 1);

	typedef enum logic [1:0] {SH_IDLE, SH_SHIFT, SH_GAP} shift_state_t;

	matrix_game_pkg::max_word_t q_mem [`MG_QUEUE_DEPTH];
	logic [PTR_W-1:0]           wr_ptr;
	logic [PTR_W-1:0]           rd_ptr;
	logic [CNT_W-1:0]           q_cnt;
	shift_state_t               state;
	matrix_game_pkg::max_word_t shift_reg;
	logic [3:0]                 bit_cnt;
	logic [DIV_W-1:0]           div_cnt;
	logic                       half_done;
	logic                       start;

	assign half_done = (div_cnt == DIV_W'(`MG_SCLK_HALF - 1));
	// Next word may start straight out of the ncs high gap
	assign start = (q_cnt != '0) &&
		(state == SH_IDLE || (state == SH_GAP && half_done));

	// ##################################################
	// Word queue
	always_ff @(posedge clock_50) begin
		if (word_valid) begin
			q_mem[wr_ptr] <= word;
		end
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt  <= '0;
		end else begin
			if (word_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(`MG_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (start) begin
				rd_ptr <= (rd_ptr == PTR_W'(`MG_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
			q_cnt <= q_cnt + CNT_W'(word_valid) - CNT_W'(start);
		end
	end

	// ##################################################
	// Shifter and serial clock
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state         <= SH_IDLE;
			shift_reg     <= '0;
			bit_cnt       <= '0;
			div_cnt       <= '0;
			max7219_din   <= 1'b0;
			max7219_ncs   <= 1'b1;
			max7219_clk   <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			div_cnt       <= (half_done || state == SH_IDLE) ? '0 : div_cnt + DIV_W'(1);
			credit_return <= (state == SH_GAP) && half_done;
			if (start) begin
				state       <= SH_SHIFT;
				shift_reg   <= q_mem[rd_ptr];
				max7219_din <= q_mem[rd_ptr][15];
				max7219_ncs <= 1'b0;
				bit_cnt     <= '0;
			end else begin
				case (state)
					SH_SHIFT: begin
						if (half_done && !max7219_clk) begin
							max7219_clk <= 1'b1;
						end else if (half_done) begin
							// Falling edge closes the bit, din moves with it
							max7219_clk <= 1'b0;
							if (bit_cnt == 4'd15) begin
								max7219_ncs <= 1'b1;
								max7219_din <= 1'b0;
								state       <= SH_GAP;
							end else begin
								shift_reg   <= {shift_reg[14:0], 1'b0};
								max7219_din <= shift_reg[14];
								bit_cnt     <= bit_cnt + 4'd1;
							end
						end
					end
					SH_GAP: begin
						if (half_done) begin
							state <= SH_IDLE;
						end
					end
					default: state <= SH_IDLE;
				endcase
			end
		end
	end

endmodule

/* verilog/matrix_game_top.sv */
// Top level of the falling-dot game
// Buttons feed the dot controller, whose cell the composer turns into MAX7219 words
// The serializer drives the matrix pins
`timescale 1ns/100ps

module matrix_game_top (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_btn_n,
	input  logic left_btn_n,
	input  logic right_btn_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);
	logic                       start_press;
	logic                       left_press;
	logic                       right_press;
	matrix_game_pkg::row_idx_t  dot_row;
	matrix_game_pkg::col_idx_t  dot_col;
	logic                       word_valid;
	matrix_game_pkg::max_word_t word;
	logic                       credit_return;

	// ##################################################
	// Button conditioning
	button_debounce u_start_btn (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.btn_n(start_btn_n),
		.press(start_press)
	);
	button_debounce u_left_btn (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.btn_n(left_btn_n),
		.press(left_press)
	);
	button_debounce u_right_btn (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.btn_n(right_btn_n),
		.press(right_press)
	);

	// ##################################################
	// Game, frame and serial link
	dot_controller u_dot (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.start_press(start_press),
		.left_press(left_press),
		.right_press(right_press),
		.dot_row(dot_row),
		.dot_col(dot_col)
	);

	frame_composer u_composer (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.dot_row(dot_row),
		.dot_col(dot_col),
		.credit_return(credit_return),
		.word_valid(word_valid),
		.word(word)
	);

	max7219_serializer u_serializer (
		.clock_50(clock_50),
		.rst_n(rst_n),
		.word_valid(word_valid),
		.word(word),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk),
		.credit_return(credit_return)
	);

endmodule

/* verif/matrix_game_assertions.sv */
// Concurrent checks on the MAX7219 serial port and the word credits of the game
// Bound into the top level so that every run of the game carries them
`timescale 1ns/100ps
`include "matrix_game_defines.svh"

module matrix_game_assertions (
	input logic clock_50,
	input logic rst_n,
	input logic max7219_ncs,
	input logic max7219_clk,
	input logic max7219_din,
	input logic word_valid,
	input logic credit_return
);
	int         frame_fails  = 0;
	int         din_fails    = 0;
	int         credit_fails = 0;
	logic       sclk_q;
	logic [4:0] rise_cnt;
	int         credits;

	// Counts rising clk edges inside the current ncs window and tracks credits on the link
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			sclk_q   <= 1'b0;
			rise_cnt <= '0;
			credits  <= `MG_QUEUE_DEPTH;
		end else begin
			sclk_q  <= max7219_clk;
			credits <= credits - int'(word_valid) + int'(credit_return);
			if (max7219_ncs) begin
				rise_cnt <= '0;
			end else if (max7219_clk && !sclk_q) begin
				rise_cnt <= rise_cnt + 5'd1;
			end
		end
	end

	// ##################################################
	ncs_window: assert property (@(posedge clock_50) disable iff (!rst_n)
		$rose(max7219_ncs) |-> (rise_cnt == 5'd16))
		else begin
			$error("ncs window closed without exactly 16 clk pulses");
			frame_fails++;
		end

	din_stable: assert property (@(posedge clock_50) disable iff (!rst_n)
		max7219_clk |-> $stable(max7219_din))
		else begin
			$error("din moved while clk was high");
			din_fails++;
		end

	credit_range: assert property (@(posedge clock_50) disable iff (!rst_n)
		(credits >= 0) && (credits <= `MG_QUEUE_DEPTH))
		else begin
			$error("credit count left its range");
			credit_fails++;
		end

endmodule

bind matrix_game_top matrix_game_assertions u_assert (
	.clock_50(clock_50),
	.rst_n(rst_n),
	.max7219_ncs(max7219_ncs),
	.max7219_clk(max7219_clk),
	.max7219_din(max7219_din),
	.word_valid(word_valid),
	.credit_return(credit_return)
);

/* verif/matrix_game_tb.sv */
// Testbench for the falling-dot game on the MAX7219 matrix
// Presses the buttons, rebuilds each serial word from the pins and checks start-up and frames
`timescale 1ns/100ps
`include "matrix_game_defines.svh"

module matrix_game_tb;
	localparam int WORD_CYC   = 16 * 2 * `MG_SCLK_HALF + `MG_SCLK_HALF + 2;
	localparam int BUDGET_CYC = 80 * 8 * WORD_CYC + 30 * `MG_FALL_TICKS;
	localparam int BTN_START  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_RIGHT  = 2;
	localparam logic [7:0] BG [8] = '{`MG_BG_ROW0, `MG_BG_ROW1, `MG_BG_ROW2, `MG_BG_ROW3,
		`MG_BG_ROW4, `MG_BG_ROW5, `MG_BG_ROW6, `MG_BG_ROW7};

	logic        clock_50;
	logic        rst_n;
	logic        start_btn_n;
	logic        left_btn_n;
	logic        right_btn_n;
	logic        max7219_din;
	logic        max7219_ncs;
	logic        max7219_clk;
	logic [15:0] shift_in;
	logic [15:0] words [$];
	logic [15:0] startup [4];
	logic [15:0] w;
	logic [31:0] lfsr_state = 32'h5619f591;
	int          errors = 0;
	int          mark = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          exp_addr = 1;
	int          last_row = 7;
	int          glitch_len;
	int          total;

	matrix_game_top dut (.*);

	initial begin
		clock_50 = 1'b0;
		forever #4 clock_50 = ~clock_50;
	end

	initial begin
		repeat (BUDGET_CYC) @(posedge clock_50);
		$display("Watchdog expired after %0d cycles with tests still running", BUDGET_CYC);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ##################################################
	// Serial capture of one bit per rising clk edge inside the ncs window
	always @(posedge max7219_clk) begin
		if (!max7219_ncs) begin
			shift_in = {shift_in[14:0], max7219_din};
		end
	end

	always @(posedge max7219_ncs) begin
		if (rst_n) begin
			words.push_back(shift_in);
		end
	end

	function automatic bit lfsr_bit();
		bit fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != mark) begin
			tests_failed++;
		end
		$display("Test %0d %s done with %0d errors", tests_run, name, errors - mark);
		mark = errors;
	endtask

	task automatic pop_word(output logic [15:0] word);
		while (words.size() == 0) begin
			@(posedge clock_50);
		end
		word = words.pop_front();
	endtask

	// Takes one digit word in address order where only the dot may differ from the background
	task automatic take_digit(input int col, output int row, output bit has_dot);
		logic [15:0] word;
		logic [7:0]  diff;
		pop_word(word);
		row     = int'(word[11:8]) - 1;
		has_dot = 1'b0;
		assert (word[15:12] == 4'h0 && int'(word[11:8]) == exp_addr)
			else report_error($sformatf("digit address %0d, expected %0d", word[11:8], exp_addr));
		exp_addr = (exp_addr == 8) ? 1 : exp_addr + 1;
		diff = word[7:0] ^ BG[3'(row)];
		if (col >= 0) begin
			assert (diff == 8'h00 || diff == 8'(1 << col))
				else report_error($sformatf("row %0d data %b, dot column %0d", row, word[7:0], col));
			has_dot = (diff != 8'h00);
			if (has_dot) begin
				assert (row <= last_row) else report_error($sformatf("dot rose to row %0d", row));
				last_row = row;
			end
		end
	endtask

	task automatic check_frame(input int dot_row, input int dot_col);
		int row;
		bit has_dot;
		repeat (8) begin
			take_digit(dot_col, row, has_dot);
			assert (has_dot == (row == dot_row))
				else report_error($sformatf("row %0d, dot expected at row %0d", row, dot_row));
		end
	endtask

	task automatic run_frames(input int n, input int col);
		int row;
		bit has_dot;
		repeat (8 * n) begin
			take_digit(col, row, has_dot);
		end
	endtask

	task automatic wait_row(input int target, input int col);
		int row;
		bit has_dot;
		do begin
			take_digit(col, row, has_dot);
		end while (!(has_dot && row == target));
	endtask

	// Drops the words issued before the last press took effect, as two may still be in flight
	task automatic resync();
		int row;
		bit has_dot;
		while (words.size() > 0) begin
			take_digit(-1, row, has_dot);
		end
		repeat (3) begin
			take_digit(-1, row, has_dot);
		end
		last_row = 7;
	endtask

	task automatic press_button(input int which);
		@(posedge clock_50);
		case (which)
			BTN_LEFT:  left_btn_n  <= 1'b0;
			BTN_RIGHT: right_btn_n <= 1'b0;
			default:   start_btn_n <= 1'b0;
		endcase
		repeat (`MG_DEBOUNCE_CYCLES + 4) @(posedge clock_50);
		start_btn_n <= 1'b1;
		left_btn_n  <= 1'b1;
		right_btn_n <= 1'b1;
		repeat (`MG_DEBOUNCE_CYCLES + 4) @(posedge clock_50);
	endtask

	task automatic glitch_start(input int len);
		@(posedge clock_50);
		start_btn_n <= 1'b0;
		repeat (len) @(posedge clock_50);
		start_btn_n <= 1'b1;
		repeat (`MG_DEBOUNCE_CYCLES) @(posedge clock_50);
	endtask

	// ##################################################
	initial begin
		rst_n       = 1'b0;
		start_btn_n = 1'b1;
		left_btn_n  = 1'b1;
		right_btn_n = 1'b1;
		shift_in    = '0;
		startup[0]  = {4'h0, matrix_game_pkg::REG_DECODE, 8'h00};
		startup[1]  = {4'h0, matrix_game_pkg::REG_INTENSITY, 4'h0, `MG_INTENSITY};
		startup[2]  = {4'h0, matrix_game_pkg::REG_SCAN_LIMIT, 8'h07};
		startup[3]  = {4'h0, matrix_game_pkg::REG_SHUTDOWN, 8'h01};
		// Reset spans 16 rising edges with the port sampled on the falling edges between them
		repeat (15) begin
			@(negedge clock_50);
			assert (max7219_ncs === 1'b1 && max7219_clk === 1'b0)
				else report_error("serial port active during reset");
		end
		@(posedge clock_50);
		rst_n <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			pop_word(w);
			assert (w == startup[i])
				else report_error($sformatf("start-up word %0d is %h, expected %h", i, w, startup[i]));
		end
		end_test("reset and start-up");

		check_frame(7, 4);
		check_frame(7, 4);
		end_test("idle refresh");

		press_button(BTN_START);
		resync();
		wait_row(0, 4);
		run_frames(5, 4);
		check_frame(0, 4);
		end_test("fall to the bottom");

		// Respawn followed by moves made before the first fall tick
		press_button(BTN_START);
		resync();
		check_frame(7, 4);
		press_button(BTN_START);
		press_button(BTN_LEFT);
		resync();
		wait_row(5, 5);
		run_frames(5, 5);
		check_frame(5, 5);
		press_button(BTN_START);
		press_button(BTN_START);
		press_button(BTN_RIGHT);
		resync();
		wait_row(0, 3);
		run_frames(5, 3);
		check_frame(0, 3);
		end_test("side moves and landing");

		press_button(BTN_START);
		resync();
		repeat (8) begin
			glitch_len = 1 + int'({lfsr_bit(), lfsr_bit()}) % (`MG_DEBOUNCE_CYCLES - 1);
			glitch_start(glitch_len);
		end
		run_frames(5, 4);
		check_frame(7, 4);
		press_button(BTN_START);
		resync();
		wait_row(6, 4);
		end_test("debounce");

		total = errors + dut.u_assert.frame_fails + dut.u_assert.din_fails +
			dut.u_assert.credit_fails;
		$display("Tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, total - errors);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+verilog
verilog/matrix_game_pkg.sv
verilog/button_debounce.sv
verilog/dot_controller.sv
verilog/frame_composer.sv
verilog/max7219_serializer.sv
verilog/matrix_game_top.sv
verif/matrix_game_assertions.sv
verif/matrix_game_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= matrix_game_tb
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, FLAGS, OBJ_DIR, ERR_LIMIT"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f project.f
	@out=$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
